/* hw/dbg_pkg.sv */
// *******************************************************************
// Debug front end shared types: TAP states, IR codes, DMI words and
// debug module register addresses
// *******************************************************************

package dbg_pkg;

	// TAP controller states, IEEE 1149.1 order
	typedef enum logic [3:0] {
		test_logic_reset = 4'h0,
		run_test_idle    = 4'h1,
		select_dr_scan   = 4'h2,
		capture_dr       = 4'h3,
		shift_dr         = 4'h4,
		exit1_dr         = 4'h5,
		pause_dr         = 4'h6,
		exit2_dr         = 4'h7,
		update_dr        = 4'h8,
		select_ir_scan   = 4'h9,
		capture_ir       = 4'ha,
		shift_ir         = 4'hb,
		exit1_ir         = 4'hc,
		pause_ir         = 4'hd,
		exit2_ir         = 4'he,
		update_ir        = 4'hf
	} tap_state_e;

	// Strobes at detected TCK rising edges
	typedef struct packed {
		logic shift_dr;
		logic capture_dr;
		logic update_dr;
		logic shift_ir;
		logic capture_ir;
		logic update_ir;
	} tap_ctl_t;

	typedef enum logic [4:0] {
		IR_IDCODE = 5'h01,
		IR_DTMCS  = 5'h10,
		IR_DMI    = 5'h11,
		IR_BYPASS = 5'h1f
	} ir_e;

	localparam int DMI_ABITS = 7;

	typedef enum logic [1:0] {
		DMI_OP_NOP   = 2'd0,
		DMI_OP_READ  = 2'd1,
		DMI_OP_WRITE = 2'd2
	} dmi_op_e;

	// Op sits in the low bits, so it is shifted in first
	typedef struct packed {
		logic [DMI_ABITS-1:0] addr;
		logic [31:0]          wdata;
		dmi_op_e              op;
	} dmi_req_t;

	typedef struct packed {
		logic [DMI_ABITS-1:0] addr;
		logic [31:0]          data;
		logic [1:0]           status;
	} dmi_scan_rsp_t;

	// Request view at update, response view at capture
	typedef union packed {
		dmi_req_t      req;
		dmi_scan_rsp_t rsp;
	} dmi_word_u;

	typedef struct packed {
		logic [31:0] rdata;
	} dmi_rsp_t;

	localparam logic [DMI_ABITS-1:0] DM_DATA0     = 7'h04;
	localparam logic [DMI_ABITS-1:0] DM_DMCONTROL = 7'h10;
	localparam logic [DMI_ABITS-1:0] DM_DMSTATUS  = 7'h11;

	// dtmcs: abits in [9:4], version 1 (0.13) in [3:0]
	localparam logic [31:0] DTMCS_VALUE = {22'h0, 6'(DMI_ABITS), 4'h1};

endpackage

/* hw/jtag_tap_fsm.sv */
// *******************************************************************
// JTAG TAP controller, oversampling TCK, TMS and TDI in the clk domain
// *******************************************************************

`timescale 1ns/1ps

module jtag_tap_fsm (
	input  logic              clk,
	input  logic              i_rst_n,
	input  logic              i_tck,
	input  logic              i_tms,
	input  logic              i_tdi,
	output dbg_pkg::tap_ctl_t o_ctl,
	output logic              o_tdi,
	output logic              o_tck_fall
);
	import dbg_pkg::*;

	logic [1:0] tck_sync;
	logic [1:0] tms_sync;
	logic [1:0] tdi_sync;
	logic       tck_prev;
	logic       tck_rise;
	tap_state_e state;
	tap_state_e state_next;

	// Two flop synchronisers, plus one more stage on TCK for edge detect
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			tck_sync <= 2'b00;
			tms_sync <= 2'b00;
			tdi_sync <= 2'b00;
			tck_prev <= 1'b0;
		end else begin
			tck_sync <= {tck_sync[0], i_tck};
			tms_sync <= {tms_sync[0], i_tms};
			tdi_sync <= {tdi_sync[0], i_tdi};
			tck_prev <= tck_sync[1];
		end
	end

	assign tck_rise   = tck_sync[1] & ~tck_prev;
	assign o_tck_fall = ~tck_sync[1] & tck_prev;
	assign o_tdi      = tdi_sync[1];

	always_comb begin
		case (state)
		test_logic_reset: state_next = tms_sync[1] ? test_logic_reset : run_test_idle;
		run_test_idle:    state_next = tms_sync[1] ? select_dr_scan : run_test_idle;
		select_dr_scan:   state_next = tms_sync[1] ? select_ir_scan : capture_dr;
		capture_dr:       state_next = tms_sync[1] ? exit1_dr : shift_dr;
		shift_dr:         state_next = tms_sync[1] ? exit1_dr : shift_dr;
		exit1_dr:         state_next = tms_sync[1] ? update_dr : pause_dr;
		pause_dr:         state_next = tms_sync[1] ? exit2_dr : pause_dr;
		exit2_dr:         state_next = tms_sync[1] ? update_dr : shift_dr;
		update_dr:        state_next = tms_sync[1] ? select_dr_scan : run_test_idle;
		select_ir_scan:   state_next = tms_sync[1] ? test_logic_reset : capture_ir;
		capture_ir:       state_next = tms_sync[1] ? exit1_ir : shift_ir;
		shift_ir:         state_next = tms_sync[1] ? exit1_ir : shift_ir;
		exit1_ir:         state_next = tms_sync[1] ? update_ir : pause_ir;
		pause_ir:         state_next = tms_sync[1] ? exit2_ir : pause_ir;
		exit2_ir:         state_next = tms_sync[1] ? update_ir : shift_ir;
		default:          state_next = tms_sync[1] ? select_dr_scan : run_test_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state <= test_logic_reset;
		end else if (tck_rise) begin
			state <= state_next;
		end
	end

	// Action happens on the rising edge that leaves the state
	assign o_ctl.capture_dr = tck_rise && (state == capture_dr);
	assign o_ctl.shift_dr   = tck_rise && (state == shift_dr);
	assign o_ctl.update_dr  = tck_rise && (state == update_dr);
	assign o_ctl.capture_ir = tck_rise && (state == capture_ir);
	assign o_ctl.shift_ir   = tck_rise && (state == shift_ir);
	assign o_ctl.update_ir  = tck_rise && (state == update_ir);

endmodule

/* hw/jtag_dtm.sv */
// *******************************************************************
// JTAG DTM: IR, IDCODE, DTMCS, BYPASS and DMI scan chains
// *******************************************************************

`timescale 1ns/1ps

module jtag_dtm #(
	parameter logic [31:0] IDCODE = 32'h00000001
) (
	input  logic              clk,
	input  logic              i_rst_n,
	input  dbg_pkg::tap_ctl_t i_ctl,
	input  logic              i_tdi,
	input  logic              i_tck_fall,
	output logic              o_tdo,
	output logic              o_dmi_req,
	output dbg_pkg::dmi_req_t o_dmi_req_data,
	input  logic              i_dmi_rsp,
	input  dbg_pkg::dmi_rsp_t i_dmi_rsp_data
);
	import dbg_pkg::*;

	logic [4:0]  ir;
	logic [4:0]  ir_sr;
	logic        sel_ir;
	dmi_word_u   dr;
	dmi_word_u   dr_capture;
	logic [31:0] rsp_rdata;
	logic        dmi_update;

	// Instruction register
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			ir     <= IR_IDCODE;
			sel_ir <= 1'b0;
		end else begin
			if (i_ctl.capture_ir) begin
				sel_ir <= 1'b1;
			end else if (i_ctl.capture_dr) begin
				sel_ir <= 1'b0;
			end
			if (i_ctl.update_ir) begin
				ir <= ir_sr;
			end
		end
	end

	// Low bits 01 are required at capture by 1149.1
	always_ff @(posedge clk) begin
		if (i_ctl.capture_ir) begin
			ir_sr <= 5'b00001;
		end else if (i_ctl.shift_ir) begin
			ir_sr <= {i_tdi, ir_sr[4:1]};
		end
	end

	always_comb begin
		dr_capture = '0;
		case (ir)
		IR_IDCODE: dr_capture[31:0] = IDCODE;
		IR_DTMCS:  dr_capture[31:0] = DTMCS_VALUE;
		IR_DMI: begin
			dr_capture.rsp.addr   = o_dmi_req_data.addr;
			dr_capture.rsp.data   = rsp_rdata;
			dr_capture.rsp.status = 2'b00;
		end
		default: dr_capture = '0;
		endcase
	end

	// Data register, length follows IR
	always_ff @(posedge clk) begin
		if (i_ctl.capture_dr) begin
			dr <= dr_capture;
		end else if (i_ctl.shift_dr) begin
			case (ir)
			IR_DMI:              dr <= {i_tdi, dr[40:1]};
			IR_IDCODE, IR_DTMCS: dr[31:0] <= {i_tdi, dr[31:1]};
			default:             dr[0] <= i_tdi;
			endcase
		end
	end

	assign dmi_update = i_ctl.update_dr && (ir == IR_DMI) && (dr.req.op != DMI_OP_NOP);

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_dmi_req      <= 1'b0;
			o_dmi_req_data <= '0;
			rsp_rdata      <= '0;
			o_tdo          <= 1'b0;
		end else begin
			o_dmi_req <= dmi_update;
			if (dmi_update) begin
				o_dmi_req_data <= dr.req;
			end
			// Held until the next DMI capture
			if (i_dmi_rsp) begin
				rsp_rdata <= i_dmi_rsp_data.rdata;
			end
			if (i_tck_fall) begin
				o_tdo <= sel_ir ? ir_sr[0] : dr[0];
			end
		end
	end

endmodule

/* hw/dm_regs.sv */
// *******************************************************************
// Debug module registers for one hart: data0, dmcontrol, dmstatus
// *******************************************************************

`timescale 1ns/1ps

module dm_regs (
	input  logic              clk,
	input  logic              i_rst_n,
	input  logic              i_dmi_req,
	input  dbg_pkg::dmi_req_t i_dmi_req_data,
	output logic              o_dmi_rsp,
	output dbg_pkg::dmi_rsp_t o_dmi_rsp_data,
	output logic              o_ndmreset,
	output logic              o_hart_req_halt,
	output logic              o_hart_req_resume,
	input  logic              i_hart_halted,
	input  logic              i_hart_running,
	output logic [31:0]       o_hart_data0_wdata,
	output logic              o_hart_data0_wen,
	input  logic [31:0]       i_hart_data0_rdata
);
	import dbg_pkg::*;

	logic        dmactive;
	logic        haltreq;
	logic [31:0] data0;
	logic [31:0] dmstatus;
	logic [31:0] rdata;
	logic        dmi_wr;
	logic        wr_dmcontrol;
	logic        wr_data0;
	logic [31:0] wdata;

	assign dmi_wr       = i_dmi_req && (i_dmi_req_data.op == DMI_OP_WRITE);
	assign wr_dmcontrol = dmi_wr && (i_dmi_req_data.addr == DM_DMCONTROL);
	assign wr_data0     = dmi_wr && (i_dmi_req_data.addr == DM_DATA0);
	assign wdata        = i_dmi_req_data.wdata;

	// dmcontrol, other fields only take writes once dmactive is set
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			dmactive          <= 1'b0;
			o_ndmreset        <= 1'b0;
			haltreq           <= 1'b0;
			o_hart_req_resume <= 1'b0;
		end else begin
			o_hart_req_resume <= 1'b0;
			if (wr_dmcontrol) begin
				dmactive <= wdata[0];
			end
			if (!dmactive) begin
				o_ndmreset <= 1'b0;
				haltreq    <= 1'b0;
			end else if (wr_dmcontrol) begin
				o_ndmreset        <= wdata[1] && wdata[0];
				haltreq           <= wdata[31] && wdata[0];
				// resumereq is ignored while haltreq is also set
				o_hart_req_resume <= wdata[30] && !wdata[31] && wdata[0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			data0            <= '0;
			o_hart_data0_wen <= 1'b0;
		end else begin
			o_hart_data0_wen <= wr_data0 && dmactive;
			if (!dmactive) begin
				data0 <= '0;
			end else if (wr_data0) begin
				data0 <= wdata;
			end
		end
	end

	assign o_hart_data0_wdata = data0;
	assign o_hart_req_halt    = haltreq && dmactive;

	// Single hart, so the any and all flags are the same; version 2
	assign dmstatus = {20'h0, i_hart_running, i_hart_running, i_hart_halted, i_hart_halted,
		4'h0, 4'd2};

	always_comb begin
		rdata = '0;
		case (i_dmi_req_data.addr)
		DM_DATA0: begin
			// A halted hart owns data0, so return its copy
			if (dmactive) begin
				rdata = i_hart_halted ? i_hart_data0_rdata : data0;
			end
		end
		DM_DMCONTROL: rdata = {haltreq, 29'h0, o_ndmreset, dmactive};
		DM_DMSTATUS:  rdata = dmstatus;
		default:      rdata = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_dmi_rsp <= 1'b0;
		end else begin
			o_dmi_rsp <= i_dmi_req;
		end
	end

	// Read value from before any write in the same request
	always_ff @(posedge clk) begin
		if (i_dmi_req) begin
			o_dmi_rsp_data.rdata <= rdata;
		end
	end

endmodule

/* hw/hart_reset_timer.sv */
// *******************************************************************
// Hart reset stretcher, fixed length after power-on reset or ndmreset
// *******************************************************************

`timescale 1ns/1ps

module hart_reset_timer #(
	parameter int RESET_CYCLES = 8
) (
	input  logic clk,
	input  logic i_rst_n,
	input  logic i_ndmreset,
	output logic o_hart_rst_n
);

	localparam int CW = $clog2(RESET_CYCLES + 1);

	logic [CW-1:0] count;
	logic          cause;

	assign cause = !i_rst_n || i_ndmreset;

	// Reload while any cause is present, then count down to zero
	always_ff @(posedge clk) begin
		if (cause) begin
			count <= CW'(RESET_CYCLES);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// ndmreset also pulls reset low in the cycle it rises
	assign o_hart_rst_n = !i_ndmreset && (count == '0);

endmodule

/* hw/dbg_top.sv */
// *******************************************************************
// JTAG debug front end: TAP, DTM, debug module and hart reset timer
// *******************************************************************

`timescale 1ns/1ps

module dbg_top #(
	parameter logic [31:0] IDCODE       = 32'h1beef0d3,
	parameter int          RESET_CYCLES = 8
) (
	input  logic        clk,
	input  logic        i_rst_n,

	// JTAG pins
	input  logic        i_tck,
	input  logic        i_tms,
	input  logic        i_tdi,
	output logic        o_tdo,

	// Hart debug interface
	output logic        o_hart_rst_n,
	output logic        o_hart_req_halt,
	output logic        o_hart_req_resume,
	output logic [31:0] o_hart_data0_wdata,
	output logic        o_hart_data0_wen,
	input  logic        i_hart_halted,
	input  logic        i_hart_running,
	input  logic [31:0] i_hart_data0_rdata
);
	import dbg_pkg::*;

	tap_ctl_t tap_ctl;
	logic     tdi_sync;
	logic     tck_fall;
	logic     dmi_req;
	dmi_req_t dmi_req_data;
	logic     dmi_rsp;
	dmi_rsp_t dmi_rsp_data;
	logic     ndmreset;

	jtag_tap_fsm u_tap (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_tck      (i_tck),
		.i_tms      (i_tms),
		.i_tdi      (i_tdi),
		.o_ctl      (tap_ctl),
		.o_tdi      (tdi_sync),
		.o_tck_fall (tck_fall)
	);

	jtag_dtm #(
		.IDCODE (IDCODE)
	) u_dtm (
		.clk            (clk),
		.i_rst_n        (i_rst_n),
		.i_ctl          (tap_ctl),
		.i_tdi          (tdi_sync),
		.i_tck_fall     (tck_fall),
		.o_tdo          (o_tdo),
		.o_dmi_req      (dmi_req),
		.o_dmi_req_data (dmi_req_data),
		.i_dmi_rsp      (dmi_rsp),
		.i_dmi_rsp_data (dmi_rsp_data)
	);

	dm_regs u_dm (
		.clk                (clk),
		.i_rst_n            (i_rst_n),
		.i_dmi_req          (dmi_req),
		.i_dmi_req_data     (dmi_req_data),
		.o_dmi_rsp          (dmi_rsp),
		.o_dmi_rsp_data     (dmi_rsp_data),
		.o_ndmreset         (ndmreset),
		.o_hart_req_halt    (o_hart_req_halt),
		.o_hart_req_resume  (o_hart_req_resume),
		.i_hart_halted      (i_hart_halted),
		.i_hart_running     (i_hart_running),
		.o_hart_data0_wdata (o_hart_data0_wdata),
		.o_hart_data0_wen   (o_hart_data0_wen),
		.i_hart_data0_rdata (i_hart_data0_rdata)
	);

	hart_reset_timer #(
		.RESET_CYCLES (RESET_CYCLES)
	) u_rst_timer (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_ndmreset   (ndmreset),
		.o_hart_rst_n (o_hart_rst_n)
	);

endmodule

/* bench/dbg_top_sva.sv */
// *******************************************************************
// Bound checks on hart reset stretch, halt/resume control and DMI strobes
// *******************************************************************

`timescale 1ns/1ps

module dbg_top_sva #(
	parameter int RESET_CYCLES = 8
) (
	input logic              clk,
	input logic              i_rst_n,
	input logic              i_dmi_req,
	input dbg_pkg::dmi_req_t i_dmi_req_data,
	input logic              i_dmi_rsp,
	input logic              i_ndmreset,
	input logic              i_hart_rst_n,
	input logic              i_hart_req_halt,
	input logic              i_hart_req_resume,
	input logic              i_hart_data0_wen,
	input logic [31:0]       i_hart_data0_wdata
);
	import dbg_pkg::*;

	logic        cause;
	logic        wr_ctl;
	logic        wr_data0;
	logic        wr_resume;
	logic        active;
	logic [31:0] wdata;
	int unsigned quiet;

	assign cause    = !i_rst_n || i_ndmreset;
	assign wdata    = i_dmi_req_data.wdata;
	assign wr_ctl   = i_dmi_req && (i_dmi_req_data.op == DMI_OP_WRITE)
		&& (i_dmi_req_data.addr == DM_DMCONTROL);
	assign wr_data0 = i_dmi_req && (i_dmi_req_data.op == DMI_OP_WRITE)
		&& (i_dmi_req_data.addr == DM_DATA0);
	assign wr_resume = wr_ctl && active && wdata[30] && !wdata[31] && wdata[0];

	// dmactive as the debug module should hold it
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			active <= 1'b0;
		end else if (wr_ctl) begin
			active <= wdata[0];
		end
	end

	// Saturating count of cycles since the last reset cause
	always_ff @(posedge clk) begin
		if (cause) begin
			quiet <= 0;
		end else if (quiet < RESET_CYCLES) begin
			quiet <= quiet + 1;
		end
	end

	rst_holds_hart: assert property (@(posedge clk) !i_rst_n |=> !i_hart_rst_n)
		else $error("hart reset released while i_rst_n is low");

	reset_stretch: assert property (@(posedge clk)
		i_rst_n |-> (i_hart_rst_n == (!i_ndmreset && (quiet == RESET_CYCLES))))
		else $error("hart reset not low during ndmreset or not released RESET_CYCLES later");

	dmi_rsp_follows: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_dmi_req |=> i_dmi_rsp && !i_dmi_req)
		else $error("DMI request is not a single strobe answered one cycle later");

	halt_rises: assert property (@(posedge clk) disable iff (!i_rst_n)
		wr_ctl && active && wdata[31] && wdata[0] |=> i_hart_req_halt)
		else $error("halt request missing one cycle after haltreq write");

	halt_clears: assert property (@(posedge clk) disable iff (!i_rst_n)
		wr_ctl && !wdata[0] |=> !i_hart_req_halt)
		else $error("halt request still set after dmactive cleared");

	resume_rises: assert property (@(posedge clk) disable iff (!i_rst_n)
		wr_resume |=> i_hart_req_resume)
		else $error("resume pulse missing one cycle after resumereq write");

	resume_single: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_hart_req_resume |=> !i_hart_req_resume)
		else $error("resume pulse longer than one cycle");

	resume_cause: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_hart_req_resume |-> $past(wr_resume))
		else $error("resume pulse without a resumereq write");

	data0_to_hart: assert property (@(posedge clk) disable iff (!i_rst_n)
		wr_data0 && active |=> i_hart_data0_wen && (i_hart_data0_wdata == $past(wdata)))
		else $error("data0 write not passed to the hart one cycle later");

endmodule

bind dbg_top dbg_top_sva #(
	.RESET_CYCLES (RESET_CYCLES)
) u_sva (
	.clk                (clk),
	.i_rst_n            (i_rst_n),
	.i_dmi_req          (dmi_req),
	.i_dmi_req_data     (dmi_req_data),
	.i_dmi_rsp          (dmi_rsp),
	.i_ndmreset         (ndmreset),
	.i_hart_rst_n       (o_hart_rst_n),
	.i_hart_req_halt    (o_hart_req_halt),
	.i_hart_req_resume  (o_hart_req_resume),
	.i_hart_data0_wen   (o_hart_data0_wen),
	.i_hart_data0_wdata (o_hart_data0_wdata)
);

/* bench/tb_dbg_top.sv */
// *******************************************************************
// Testbench for the JTAG debug front end, with JTAG bit-bang and a hart model
// *******************************************************************

`timescale 1ns/1ps

module tb_dbg_top;

	localparam logic [31:0] IDCODE       = 32'h1beef0d3;
	localparam int          RESET_CYCLES = 8;

	localparam logic [4:0] IR_DMI    = 5'h11;
	localparam logic [4:0] IR_BYPASS = 5'h1f;

	localparam logic [6:0] DM_DATA0     = 7'h04;
	localparam logic [6:0] DM_DMCONTROL = 7'h10;
	localparam logic [6:0] DM_DMSTATUS  = 7'h11;

	localparam logic [1:0] OP_NOP   = 2'd0;
	localparam logic [1:0] OP_READ  = 2'd1;
	localparam logic [1:0] OP_WRITE = 2'd2;

	// dmstatus has allrunning at bit 11, anyrunning 10, allhalted 9, anyhalted 8 and version 2
	localparam logic [31:0] DMSTATUS_HALTED  = 32'h0000_0302;
	localparam logic [31:0] DMSTATUS_RUNNING = 32'h0000_0c02;

	// About 22 scans of up to 46 TCK periods at 8 clk each, with a wide margin
	localparam int TIMEOUT_CYCLES = 20000;

	logic        clk          = 1'b0;
	logic        rst_n        = 1'b0;
	logic        tck          = 1'b0;
	logic        tms          = 1'b1;
	logic        tdi          = 1'b0;
	logic        tdo;
	logic        hart_rst_n;
	logic        hart_req_halt;
	logic        hart_req_resume;
	logic [31:0] hart_data0_wdata;
	logic        hart_data0_wen;
	logic        hart_halted  = 1'b0;
	logic        hart_running = 1'b0;
	logic [31:0] hart_data0   = 32'h0;
	integer      seed         = 32'h5d43;
	int          cycle_count  = 0;

	dbg_top #(
		.IDCODE       (IDCODE),
		.RESET_CYCLES (RESET_CYCLES)
	) u_dut (
		.clk                (clk),
		.i_rst_n            (rst_n),
		.i_tck              (tck),
		.i_tms              (tms),
		.i_tdi              (tdi),
		.o_tdo              (tdo),
		.o_hart_rst_n       (hart_rst_n),
		.o_hart_req_halt    (hart_req_halt),
		.o_hart_req_resume  (hart_req_resume),
		.o_hart_data0_wdata (hart_data0_wdata),
		.o_hart_data0_wen   (hart_data0_wen),
		.i_hart_halted      (hart_halted),
		.i_hart_running     (hart_running),
		.i_hart_data0_rdata (hart_data0)
	);

	always #5 clk = ~clk;

	// Hart model that halts on request and runs again on a resume pulse
	always @(posedge clk) begin
		if (!hart_rst_n) begin
			hart_halted  <= 1'b0;
			hart_running <= 1'b0;
		end else if (hart_req_halt) begin
			hart_halted  <= 1'b1;
			hart_running <= 1'b0;
			// On entering halt the hart leaves its own result in data0
			if (!hart_halted) begin
				hart_data0 <= ~hart_data0;
			end
		end else if (hart_req_resume) begin
			hart_halted  <= 1'b0;
			hart_running <= 1'b1;
		end
		if (hart_data0_wen) begin
			hart_data0 <= hart_data0_wdata;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the JTAG scenario did not finish in %0d cycles", TIMEOUT_CYCLES);
			$display("TB FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else begin
			$display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1, "scan data mismatch");
		end
	endtask

	// One TCK period of 8 clk; TDO is sampled just before the rising edge
	task automatic tck_cycle(input logic tms_val, input logic tdi_val, output logic tdo_val);
		tck <= 1'b0;
		tms <= tms_val;
		tdi <= tdi_val;
		repeat (4) @(posedge clk);
		tdo_val = tdo;
		tck <= 1'b1;
		repeat (4) @(posedge clk);
	endtask

	task automatic tap_reset();
		logic bit_out;
		repeat (5) tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
	endtask

	// Both scans start and end in run_test_idle
	task automatic scan_ir(input logic [4:0] code, output logic [4:0] captured);
		int   i;
		logic bit_out;
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		for (i = 0; i < 5; i++) begin
			tck_cycle(i == 4, code[i], bit_out);
			captured[i] = bit_out;
		end
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
	endtask

	task automatic scan_dr(input int len, input logic [40:0] din, output logic [40:0] dout);
		int   i;
		logic bit_out;
		dout = '0;
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		for (i = 0; i < len; i++) begin
			tck_cycle(i == len - 1, din[i], bit_out);
			dout[i] = bit_out;
		end
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
	endtask

	// Returns the data field captured from the previous DMI access
	task automatic dmi_scan(input logic [6:0] addr, input logic [31:0] data,
		input logic [1:0] op, output logic [31:0] rdata);
		logic [40:0] dout;
		scan_dr(41, {addr, data, op}, dout);
		check_value({30'h0, dout[1:0]}, 32'h0, "DMI status");
		rdata = dout[33:2];
	endtask

	task automatic dmi_write(input logic [6:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		dmi_scan(addr, data, OP_WRITE, unused);
	endtask

	task automatic read_expect(input logic [6:0] addr, input logic [31:0] exp, input string what);
		logic [31:0] rdata;
		dmi_scan(addr, 32'h0, OP_READ, rdata);
		dmi_scan(7'h0, 32'h0, OP_NOP, rdata);
		check_value(rdata, exp, what);
	endtask

	initial begin
		logic [40:0] dout;
		logic [4:0]  ir_out;
		logic [31:0] word;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		// IDCODE is the selected instruction out of reset
		tap_reset();
		scan_dr(32, 41'h0, dout);
		check_value(dout[31:0], IDCODE, "IDCODE scan");

		scan_ir(IR_BYPASS, ir_out);
		check_value({27'h0, ir_out}, 32'h1, "IR capture");
		scan_dr(9, 41'h0a5, dout);
		check_value({23'h0, dout[8:0]}, {23'h0, 8'ha5, 1'b0}, "BYPASS delay");

		scan_ir(IR_DMI, ir_out);
		dmi_write(DM_DMCONTROL, 32'h0000_0001);

		word = $random(seed);
		dmi_write(DM_DATA0, word);
		read_expect(DM_DATA0, word, "data0 readback");

		dmi_write(DM_DMCONTROL, 32'h8000_0001);
		read_expect(DM_DMSTATUS, DMSTATUS_HALTED, "dmstatus after halt");
		read_expect(DM_DATA0, ~word, "data0 of the halted hart");

		dmi_write(DM_DMCONTROL, 32'h4000_0001);
		read_expect(DM_DMSTATUS, DMSTATUS_RUNNING, "dmstatus after resume");

		// Pulse ndmreset, then wait for the stretched hart reset to end
		dmi_write(DM_DMCONTROL, 32'h0000_0003);
		dmi_write(DM_DMCONTROL, 32'h0000_0001);
		while (!hart_rst_n) begin
			@(posedge clk);
		end

		dmi_write(DM_DMCONTROL, 32'h8000_0001);
		dmi_write(DM_DMCONTROL, 32'h0000_0000);
		read_expect(DM_DATA0, 32'h0, "data0 after deactivation");

		$display("TB PASSED");
		$finish;
	end

endmodule

/* compile.f */
hw/dbg_pkg.sv
hw/jtag_tap_fsm.sv
hw/jtag_dtm.sv
hw/dm_regs.sv
hw/hart_reset_timer.sv
hw/dbg_top.sv
bench/dbg_top_sva.sv
bench/tb_dbg_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dbg_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
SIM_ARGS  ?=

BASE_FLAGS := --timing --assert --top-module $(TOP) -f $(FILELIST)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(BASE_FLAGS) $(VFLAGS)

sim:
	$(VERILATOR) --binary $(BASE_FLAGS) $(VFLAGS) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
